//--- rtl/cache_defines.svh
// Cache geometry and main memory latency values.
`ifndef CACHE_DEFINES_SVH
`define CACHE_DEFINES_SVH

// Byte address width of the client and memory buses.
`define CACHE_ADDR_W 16
// Width of one data word.
`define CACHE_WORD_W 16
// Words held by one cache line.
`define CACHE_LINE_WORDS 8
// Number of sets, each holding two ways.
`define CACHE_SETS 64
// Cycles from an address on mem_addr with mem_en to its word with mem_data_valid.
// The fill address delay chain has one stage per cycle of this latency.
`define CACHE_MEM_LATENCY 4

`endif

//--- rtl/cache_pkg.sv
// Cache vector typedefs and the fill controller state enum.
`default_nettype none
`include "cache_defines.svh"

package cache_pkg;

  typedef logic [`CACHE_ADDR_W-1:0] addr_t;              // Byte address.
  typedef logic [`CACHE_WORD_W-1:0] word_t;              // One data word.
  typedef logic [$clog2(`CACHE_SETS)-1:0] set_idx_t;     // Set index.
  typedef logic [$clog2(`CACHE_LINE_WORDS)-1:0] word_idx_t; // Word offset in a line.

  // Tag entry layout is tag in [7:2], valid in [1], LRU in [0].
  typedef logic [7:0] tag_entry_t;

  typedef enum logic [1:0] {
    idle,        // No miss in flight.
    wait_grant,  // Miss seen, waiting on the memory arbiter.
    send         // Addresses going out and words coming back.
  } fill_state_t;

endpackage

`default_nettype wire

//--- rtl/cache_lookup.sv
// Request acceptance, tag storage, two-way compare, LRU upkeep, miss detection, response.
`default_nettype none
`include "cache_defines.svh"

module cache_lookup (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  req_valid,
  input  cache_pkg::addr_t      req_addr,
  output logic                  req_ready,
  output logic                  resp_valid,
  output cache_pkg::word_t      resp_data,
  input  logic                  resp_ready,
  output logic                  miss_detected,
  output cache_pkg::addr_t      miss_addr,
  output logic                  victim_way,
  output cache_pkg::set_idx_t   rd_set,
  output cache_pkg::word_idx_t  rd_word,
  input  cache_pkg::word_t      rd_data,
  input  logic                  fsm_busy,
  input  logic                  write_tag_array,
  input  cache_pkg::addr_t      cache_write_addr,
  input  cache_pkg::tag_entry_t tag_entry
);

  import cache_pkg::*;

  localparam int word_lsb   = $clog2(`CACHE_WORD_W / 8);                 // Byte offset in a word.
  localparam int byte_ofs_w = $clog2(`CACHE_LINE_WORDS) + word_lsb;      // Byte offset in a line.
  localparam int set_w      = $bits(set_idx_t);                          // Set index width.
  localparam int tag_lsb    = byte_ofs_w + set_w;                        // First tag bit.

  addr_t      req_addr_q;                          // Request held from acceptance to response.
  logic       lookup_cyc;                          // Tags and data are read this cycle.
  logic       data_cyc;                            // Read data of a hit is on rd_data.
  logic       miss_wait;                           // Held request waits for the fill to end.
  tag_entry_t tag_mem [`CACHE_SETS][2];            // Two tag entries per set.
  tag_entry_t entry0;                              // Way 0 entry of the addressed set.
  tag_entry_t entry1;                              // Way 1 entry of the addressed set.
  logic       hit0;                                // Way 0 matches.
  logic       hit1;                                // Way 1 matches.
  logic       hit;                                 // Either way matches.
  logic       victim;                              // Way chosen for replacement.
  set_idx_t   wr_set;                              // Set that the fill is writing.

  ////////////////////
  // Tag compare
  ////////////////////
  assign rd_set    = req_addr_q[byte_ofs_w +: set_w];            // Set of the held request.
  assign rd_word   = req_addr_q[word_lsb +: $bits(word_idx_t)];  // Word of the held request.
  assign miss_addr = req_addr_q;                                 // Fill works on the held address.
  assign wr_set    = cache_write_addr[byte_ofs_w +: set_w];

  assign entry0 = tag_mem[rd_set][0];
  assign entry1 = tag_mem[rd_set][1];
  assign hit0   = entry0[1] && (entry0[7:2] == req_addr_q[`CACHE_ADDR_W-1:tag_lsb]);
  assign hit1   = entry1[1] && (entry1[7:2] == req_addr_q[`CACHE_ADDR_W-1:tag_lsb]);
  assign hit    = hit0 || hit1;

  // An empty way is filled first, otherwise the way marked least recently used.
  assign victim = !entry0[1] ? 1'b0 :
                  !entry1[1] ? 1'b1 : entry1[0];

  assign miss_detected = lookup_cyc && !hit;       // One cycle pulse per failed lookup.

  ////////////////////
  // Request flow
  ////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      req_ready  <= 1'b1;                          // Ready for the first request.
      lookup_cyc <= 1'b0;
      data_cyc   <= 1'b0;
      miss_wait  <= 1'b0;
      resp_valid <= 1'b0;
      victim_way <= 1'b0;
    end else begin
      // A fresh request, or the replay once the fill is done, starts a lookup.
      lookup_cyc <= (req_valid && req_ready) || (miss_wait && !fsm_busy);
      data_cyc   <= lookup_cyc && hit;             // Data array output is valid next cycle.
      if (lookup_cyc) begin
        victim_way <= hit ? hit1 : victim;         // Hit way for the read, else fill way.
      end
      if (miss_detected) begin
        miss_wait <= 1'b1;                         // Busy rises at this same edge.
      end else if (!fsm_busy) begin
        miss_wait <= 1'b0;                         // Fill finished, replay goes out.
      end
      if (req_valid && req_ready) begin
        req_ready <= 1'b0;                         // One request at a time.
      end else if (resp_valid && resp_ready) begin
        req_ready <= 1'b1;
      end
      if (data_cyc) begin
        resp_valid <= 1'b1;
      end else if (resp_ready) begin
        resp_valid <= 1'b0;                        // Response taken.
      end
    end
  end

  always_ff @(posedge clk) begin
    if (req_valid && req_ready) begin
      req_addr_q <= req_addr;                      // Capture the accepted address.
    end
    if (data_cyc) begin
      resp_data <= rd_data;                        // Held until the response transfer.
    end
  end

  ////////////////////
  // Tag and LRU update
  ////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int s = 0; s < `CACHE_SETS; s++) begin
        tag_mem[s][0] <= '0;                       // All lines start invalid.
        tag_mem[s][1] <= '0;
      end
    end else if (write_tag_array) begin
      tag_mem[wr_set][victim_way]     <= tag_entry; // New line is most recently used.
      tag_mem[wr_set][~victim_way][0] <= 1'b1;      // The other way ages.
    end else if (lookup_cyc && hit) begin
      tag_mem[rd_set][hit1][0]  <= 1'b0;           // Hit way becomes most recent.
      tag_mem[rd_set][~hit1][0] <= 1'b1;
    end
  end

  // A stalled response keeps its word until the client takes it.
  resp_hold_a: assert property (@(posedge clk) disable iff (rst)
    resp_valid && !resp_ready |=> resp_valid && $stable(resp_data));

endmodule

`default_nettype wire

//--- rtl/cache_data_array.sv
// Two-way line data storage with one registered read port and one fill write port.
`default_nettype none
`include "cache_defines.svh"

module cache_data_array (
  input  logic                 clk,
  input  cache_pkg::set_idx_t  rd_set,
  input  cache_pkg::word_idx_t rd_word,
  output cache_pkg::word_t     rd_data,
  input  logic                 rd_way,
  input  logic                 write_data_array,
  input  logic                 wr_way,
  input  cache_pkg::addr_t     cache_write_addr,
  input  cache_pkg::word_t     mem_data
);

  import cache_pkg::*;

  localparam int word_lsb   = $clog2(`CACHE_WORD_W / 8);             // Byte offset in a word.
  localparam int byte_ofs_w = $clog2(`CACHE_LINE_WORDS) + word_lsb;  // Byte offset in a line.

  word_t     mem_q [`CACHE_SETS][2][`CACHE_LINE_WORDS];  // Sets by ways by words.
  word_t     rd_q [2];                                   // Addressed word of both ways.
  set_idx_t  wr_set;                                     // Set written by the fill.
  word_idx_t wr_word;                                    // Word written by the fill.

  assign wr_set  = cache_write_addr[byte_ofs_w +: $bits(set_idx_t)];
  assign wr_word = cache_write_addr[word_lsb +: $bits(word_idx_t)];

  always_ff @(posedge clk) begin
    if (write_data_array) begin
      mem_q[wr_set][wr_way][wr_word] <= mem_data;  // Memory word lands in the victim way.
    end
    rd_q[0] <= mem_q[rd_set][0][rd_word];          // Both ways are read every cycle.
    rd_q[1] <= mem_q[rd_set][1][rd_word];
  end

  // The way select arrives one cycle after the address, with the hit result.
  assign rd_data = rd_q[rd_way];

endmodule

`default_nettype wire

//--- rtl/cache_fill_ctrl.sv
// Miss fill FSM, memory address sequencer, latency delay chain and tag entry builder.
`default_nettype none
`include "cache_defines.svh"

module cache_fill_ctrl (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  miss_detected,
  input  cache_pkg::addr_t      miss_addr,
  input  logic                  mem_grant,
  input  logic                  mem_data_valid,
  output logic                  fsm_busy,
  output logic                  mem_en,
  output cache_pkg::addr_t      mem_addr,
  output logic                  write_data_array,
  output logic                  write_tag_array,
  output cache_pkg::addr_t      cache_write_addr,
  output cache_pkg::tag_entry_t tag_entry
);

  import cache_pkg::*;

  localparam int word_bytes = `CACHE_WORD_W / 8;                        // Address step per word.
  localparam int byte_ofs_w = $clog2(`CACHE_LINE_WORDS * word_bytes);   // Byte offset in a line.
  localparam int tag_lsb    = byte_ofs_w + $bits(set_idx_t);            // First tag bit.

  fill_state_t state;                              // Current state.
  fill_state_t nxt_state;                          // Next state.
  word_idx_t   word_cnt;                           // Words written into the line so far.
  addr_t       line_base;                          // First byte address of the missed line.
  addr_t       addr_pipe [`CACHE_MEM_LATENCY];     // Addresses in flight to memory.
  logic        start_fill;                         // Miss accepted, capture its line.
  logic        set_mem_en;                         // Grant seen, start sending addresses.
  logic        clr_mem_en;                         // Last address of the line is out.
  logic        last_word;                          // Next returned word closes the line.

  assign line_base  = {miss_addr[`CACHE_ADDR_W-1:byte_ofs_w], {byte_ofs_w{1'b0}}};
  assign clr_mem_en = mem_en && (mem_addr[byte_ofs_w-1:0] ==
                      byte_ofs_w'((`CACHE_LINE_WORDS - 1) * word_bytes));
  assign last_word  = word_cnt == word_idx_t'(`CACHE_LINE_WORDS - 1);

  ////////////////////
  // FSM
  ////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      state <= idle;
    end else begin
      state <= nxt_state;
    end
  end

  always_comb begin
    nxt_state        = state;                      // Hold by default.
    start_fill       = 1'b0;
    set_mem_en       = 1'b0;
    write_data_array = 1'b0;
    write_tag_array  = 1'b0;
    case (state)
      idle: begin
        if (miss_detected) begin
          start_fill = 1'b1;                       // Capture the line and go busy.
          nxt_state  = wait_grant;
        end
      end
      wait_grant: begin
        if (mem_grant) begin
          set_mem_en = 1'b1;                       // First address goes out next cycle.
          nxt_state  = send;
        end
      end
      send: begin
        if (mem_data_valid) begin
          write_data_array = 1'b1;                 // Every returned word is stored.
          if (last_word) begin
            write_tag_array = 1'b1;                // Tag goes in with the eighth word.
            nxt_state       = idle;
          end
        end
      end
      default: nxt_state = idle;                   // Recover from a corrupt state.
    endcase
  end

  // Busy and memory enable are set/clear flops.
  always_ff @(posedge clk) begin
    if (rst) begin
      fsm_busy <= 1'b0;
      mem_en   <= 1'b0;
      word_cnt <= '0;
    end else begin
      if (start_fill) begin
        fsm_busy <= 1'b1;
      end else if (write_tag_array) begin
        fsm_busy <= 1'b0;                          // Lookup replays the request after this.
      end
      if (set_mem_en) begin
        mem_en <= 1'b1;
      end else if (clr_mem_en) begin
        mem_en <= 1'b0;                            // Eight addresses sent.
      end
      if (start_fill) begin
        word_cnt <= '0;
      end else if (write_data_array) begin
        word_cnt <= word_cnt + 1'b1;
      end
    end
  end

  ////////////////////
  // Address sequencing
  ////////////////////
  always_ff @(posedge clk) begin
    if (start_fill) begin
      mem_addr  <= line_base;                      // Fill starts at the line base.
      tag_entry <= {miss_addr[`CACHE_ADDR_W-1:tag_lsb], 1'b1, 1'b0}; // Valid, not LRU.
    end else if (mem_en) begin
      mem_addr <= mem_addr + addr_t'(word_bytes);  // One word per cycle.
    end
    // Each address trails its memory request by the memory latency.
    addr_pipe[0] <= start_fill ? line_base : mem_addr;
    for (int i = 1; i < `CACHE_MEM_LATENCY; i++) begin
      addr_pipe[i] <= start_fill ? line_base : addr_pipe[i-1];
    end
  end

  assign cache_write_addr = addr_pipe[`CACHE_MEM_LATENCY-1];  // Lines up with mem_data.

  mem_en_busy_a: assert property (@(posedge clk) disable iff (rst)
    mem_en |-> fsm_busy);
  // The tag write rides on the data write of the last word of the line.
  tag_last_a: assert property (@(posedge clk) disable iff (rst)
    write_tag_array |-> write_data_array &&
    (cache_write_addr[byte_ofs_w-1:0] == byte_ofs_w'((`CACHE_LINE_WORDS - 1) * word_bytes)));
  // Busy is high exactly while the FSM is out of idle.
  state_legal_a: assert property (@(posedge clk) disable iff (rst)
    fsm_busy == (state != idle));

endmodule

`default_nettype wire

//--- rtl/cache_top.sv
// Cache top level joining lookup, data array and fill controller.
`default_nettype none

module cache_top (
  input  logic             clk,
  input  logic             rst,
  input  logic             req_valid,
  input  cache_pkg::addr_t req_addr,
  output logic             req_ready,
  output logic             resp_valid,
  output cache_pkg::word_t resp_data,
  input  logic             resp_ready,
  input  logic             mem_grant,
  input  logic             mem_data_valid,
  input  cache_pkg::word_t mem_data,
  output logic             mem_en,
  output cache_pkg::addr_t mem_addr,
  output logic             fsm_busy      // Miss in progress, arbiter holds grant until it falls.
);

  import cache_pkg::*;

  logic       miss_detected;                       // Lookup failed this cycle.
  addr_t      miss_addr;                           // Address of the held request.
  logic       victim_way;                          // Hit way on reads, fill way on misses.
  set_idx_t   rd_set;
  word_idx_t  rd_word;
  word_t      rd_data;
  logic       write_data_array;
  logic       write_tag_array;
  addr_t      cache_write_addr;                    // Delayed fill address.
  tag_entry_t tag_entry;

  cache_lookup u_lookup (.*);

  cache_data_array u_data (
    .clk, .rd_set, .rd_word, .rd_data, .rd_way(victim_way),
    .write_data_array, .wr_way(victim_way), .cache_write_addr, .mem_data
  );

  cache_fill_ctrl u_fill (.*);

endmodule

`default_nettype wire

//--- verification/mem_model.sv
// Main memory model with random contents and fixed-latency pipelined read returns.
`default_nettype none
`include "cache_defines.svh"

module mem_model (
  input  logic             clk,
  input  logic             rst,
  input  logic             mem_en,
  input  cache_pkg::addr_t mem_addr,
  output logic             mem_data_valid,
  output cache_pkg::word_t mem_data
);
  timeunit 1ns;
  timeprecision 100ps;

  import cache_pkg::*;

  localparam int depth = 2 ** (`CACHE_ADDR_W - 1);  // One entry per word of the byte space.

  integer seed = 32'hea17523d;                      // Seed of the content generator.
  word_t  words [depth];                            // Memory contents, indexed by word address.
  logic   valid_pipe [`CACHE_MEM_LATENCY] = '{default: 1'b0};  // Read requests in flight.
  word_t  data_pipe [`CACHE_MEM_LATENCY] = '{default: '0};      // Words in flight.

  initial begin
    for (int i = 0; i < depth; i++) begin
      words[i] = word_t'($random(seed));            // Every word gets its own random value.
    end
  end

  // Each read comes back exactly the memory latency after its address.
  always @(posedge clk) begin
    valid_pipe[0] <= mem_en && !rst;
    data_pipe[0]  <= words[mem_addr[`CACHE_ADDR_W-1:1]];
    for (int i = 1; i < `CACHE_MEM_LATENCY; i++) begin
      valid_pipe[i] <= valid_pipe[i-1] && !rst;
      data_pipe[i]  <= data_pipe[i-1];
    end
  end

  assign mem_data_valid = valid_pipe[`CACHE_MEM_LATENCY-1];
  assign mem_data       = data_pipe[`CACHE_MEM_LATENCY-1];

endmodule

`default_nettype wire

//--- verification/cache_tb.sv
// Cache testbench with clock, reset, client stimulus, grant driver, reference model and checks.
`default_nettype none
`include "cache_defines.svh"

module cache_tb;
  timeunit 1ns;
  timeprecision 100ps;

  import cache_pkg::*;

  logic  clk = 1'b0;
  logic  rst;
  logic  req_valid;
  addr_t req_addr;
  logic  req_ready;
  logic  resp_valid;
  word_t resp_data;
  logic  resp_ready;
  logic  mem_grant = 1'b0;                          // Arbiter grant, low until a miss.
  logic  mem_data_valid;
  word_t mem_data;
  logic  mem_en;
  addr_t mem_addr;
  logic  fsm_busy;

  integer seed = 32'hea17523d;                      // Stimulus random source.
  integer grant_seed = 32'hea17523d;                // Grant delay random source.
  int     errors;                                   // All failed checks.
  int     start_errs;                               // Error count when the current test began.
  int     tests_run;
  int     tests_failed;
  bit     timed_out;                                // A wait ran out, the rest is skipped.
  addr_t  cur_addr;                                 // Address of the read in flight.
  word_t  ref_mem [2 ** (`CACHE_ADDR_W - 1)];       // Copy of the memory contents.
  logic [5:0] ref_tag [`CACHE_SETS][2];             // Reference tags per set and way.
  bit     ref_valid [`CACHE_SETS][2];
  bit     ref_lru [`CACHE_SETS][2];                 // Set means replace this way next.
  int     en_cnt;                                   // mem_en cycles of the current fill.
  logic   busy_q;
  logic   stall_q;                                  // Response was stalled last edge.
  word_t  stall_data;
  int     grant_cnt;
  logic   grant_armed;

  cache_top dut (.*);
  mem_model mem (.*);

  always #5 clk = ~clk;                             // 10 ns clock.

  task automatic value_mismatch(input string name, input logic [15:0] got,
                                input logic [15:0] exp);
    errors++;
    $display("FAIL %s got %h expected %h", name, got, exp);
  endtask

  task automatic plain_failure(input string msg);
    errors++;
    $display("%s", msg);
  endtask

  task automatic timeout_hit(input string what);
    timed_out = 1'b1;
    plain_failure($sformatf("Timed out waiting for %s.", what));
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (errors == start_errs) begin
      $display("test %0d %s: ok", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: %0d errors", tests_run, name, errors - start_errs);
    end
    start_errs = errors;
  endtask

  ////////////////////
  // Reference model
  ////////////////////
  // Applies one read to the tag model and returns whether it hits.
  function automatic bit ref_access(input addr_t a);
    logic [5:0] s;
    bit         w;
    bit         hit;
    s   = a[9:4];                                   // Set index bits.
    hit = 1'b0;
    w   = 1'b0;
    for (int i = 0; i < 2; i++) begin
      if (ref_valid[s][i] && ref_tag[s][i] == a[15:10]) begin
        hit = 1'b1;
        w   = i[0];
      end
    end
    if (!hit) begin
      if (!ref_valid[s][0]) w = 1'b0;               // Empty ways fill first.
      else if (!ref_valid[s][1]) w = 1'b1;
      else w = ref_lru[s][0] ? 1'b0 : 1'b1;
      ref_tag[s][w]   = a[15:10];
      ref_valid[s][w] = 1'b1;
    end
    ref_lru[s][w]  = 1'b0;                          // Touched way is most recent.
    ref_lru[s][!w] = 1'b1;
    return hit;
  endfunction

  ////////////////////
  // Grant driver and monitors
  ////////////////////
  always @(posedge clk) begin
    if (rst || !fsm_busy) begin
      mem_grant   <= 1'b0;
      grant_armed <= 1'b0;
    end else if (!grant_armed) begin
      grant_armed <= 1'b1;
      grant_cnt   <= {$random(grant_seed)} % 6;    // Arbiter delay of 0 to 5 cycles.
    end else if (grant_cnt == 0) begin
      mem_grant <= 1'b1;                            // Held until busy falls.
    end else begin
      grant_cnt <= grant_cnt - 1;
    end
  end

  always @(posedge clk) begin
    if (rst) begin
      stall_q <= 1'b0;
      en_cnt  <= 0;
      busy_q  <= 1'b0;
    end else begin
      if (stall_q) begin
        assert (resp_valid) else plain_failure("resp_valid fell before the response transfer.");
        assert (resp_data == stall_data) else value_mismatch("resp_data", resp_data, stall_data);
      end
      stall_q    <= resp_valid && !resp_ready;
      stall_data <= resp_data;
      if (mem_en) begin                             // Fill walks the line of the read in flight.
        assert (mem_addr == {cur_addr[15:4], 4'h0} + 16'(en_cnt * 2))
          else value_mismatch("mem_addr", mem_addr, {cur_addr[15:4], 4'h0} + 16'(en_cnt * 2));
        en_cnt <= en_cnt + 1;
      end
      if (busy_q && !fsm_busy) begin
        assert (en_cnt == 8)
          else plain_failure($sformatf("mem_en was high for %0d cycles, not 8.", en_cnt));
        en_cnt <= 0;
      end
      busy_q <= fsm_busy;
    end
  end

  grant_first_a: assert property (@(posedge clk) disable iff (rst) mem_en |-> mem_grant)
    else plain_failure("mem_en was high without mem_grant.");
  ready_low_a: assert property (@(posedge clk) disable iff (rst) resp_valid |-> !req_ready)
    else plain_failure("req_ready was high while a response waited.");

  ////////////////////
  // Client stimulus
  ////////////////////
  // Runs one read through both handshakes and checks data, miss behavior and hit latency.
  task automatic read_word(input addr_t a, input int stall);
    bit    exp_hit;
    bit    saw_en;
    bit    done;
    int    t;
    word_t exp_data;
    if (timed_out) return;
    exp_hit  = ref_access(a);
    exp_data = ref_mem[a[15:1]];
    cur_addr = a;
    saw_en   = 1'b0;
    done     = 1'b0;
    req_valid <= 1'b1;
    req_addr  <= a;
    for (t = 0; t < 50 && !done; t++) begin
      @(posedge clk);
      done = req_ready;                             // Accepted at this edge.
    end
    req_valid <= 1'b0;
    if (!done) begin
      timeout_hit("req_ready");
      return;
    end
    done = 1'b0;
    for (t = 0; t < 200 && !done; t++) begin
      @(posedge clk);
      saw_en |= mem_en;
      done = resp_valid;
    end
    if (!done) begin
      timeout_hit("resp_valid");
      return;
    end
    // Set at the second edge after acceptance, first sampled at the third.
    assert (!exp_hit || t == 3)
      else plain_failure($sformatf("Hit response came %0d edges after acceptance.", t - 1));
    assert (saw_en == !exp_hit) else value_mismatch("mem_en", 16'(saw_en), 16'(!exp_hit));
    repeat (stall) @(posedge clk);
    resp_ready <= 1'b1;
    @(posedge clk);                                 // Response transfer.
    assert (resp_data == exp_data) else value_mismatch("resp_data", resp_data, exp_data);
    resp_ready <= 1'b0;
  endtask

  initial begin
    addr_t      a;
    addr_t      lines [3];
    logic [5:0] set0;
    logic [5:0] tag0;
    req_valid  <= 1'b0;
    req_addr   <= '0;
    resp_ready <= 1'b0;
    rst        <= 1'b1;
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    assert (req_ready) else value_mismatch("req_ready", 16'(req_ready), 16'h1);
    assert (!resp_valid) else value_mismatch("resp_valid", 16'(resp_valid), 16'h0);
    assert (!mem_en) else value_mismatch("mem_en", 16'(mem_en), 16'h0);
    assert (!fsm_busy) else value_mismatch("fsm_busy", 16'(fsm_busy), 16'h0);
    finish_test("reset state");
    for (int i = 0; i < 2 ** (`CACHE_ADDR_W - 1); i++) begin
      ref_mem[i] = mem.words[i];
    end
    a    = addr_t'($random(seed));
    a[0] = 1'b0;                                    // Word aligned.
    read_word(a, 0);
    finish_test("cold miss");
    for (int w = 0; w < 8; w++) begin
      read_word({a[15:4], w[2:0], 1'b0}, 0);
    end
    finish_test("line hits");
    set0 = a[9:4] + 6'd1;
    tag0 = 6'($random(seed));
    for (int i = 0; i < 3; i++) begin
      lines[i] = {tag0 + 6'(i), set0, 3'($random(seed)), 1'b0};  // Same set, distinct tags.
    end
    read_word(lines[0], 0);
    read_word(lines[1], 0);
    read_word(lines[0], 0);                         // Line 1 is now least recent.
    read_word(lines[2], 0);
    read_word(lines[0], 0);
    read_word(lines[1], 0);
    finish_test("LRU eviction");
    for (int i = 0; i < 6; i++) begin
      read_word(lines[{$random(seed)} % 3], {$random(seed)} % 8 + 1);
    end
    finish_test("response back-pressure");
    for (int i = 0; i < 200; i++) begin
      a = {tag0 + 6'({$random(seed)} % 4), set0 + 6'({$random(seed)} % 3),
           3'($random(seed)), 1'b0};
      read_word(a, {$random(seed)} % 3);
    end
    finish_test("random reads");
    $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0 && !timed_out) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- cache_fill.f
+incdir+rtl
rtl/cache_pkg.sv
rtl/cache_lookup.sv
rtl/cache_data_array.sv
rtl/cache_fill_ctrl.sv
rtl/cache_top.sv
verification/mem_model.sv
verification/cache_tb.sv

//--- Makefile
# Verilator build and run of the cache testbench.
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove the build folder and $(LOG)"

test:
	verilator --binary --timing --assert -f cache_fill.f --top-module cache_tb \
		--Mdir obj_dir -o cache_sim
	./obj_dir/cache_sim | tee $(LOG)
	grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
